// ==== list.f ====
+incdir+source
source/intUnitPkg.sv
source/intChainIf.sv
source/resetSequencer.sv
source/pendingLatch.sv
source/priorityResolver.sv
source/ackController.sv
source/interruptUnit.sv
sim/tbInterruptUnit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the interrupt unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tbInterruptUnit -f list.f -o tbInterruptUnit > sim.log 2>&1 &&
   ./obj_dir/tbInterruptUnit >> sim.log 2>&1 ||
   echo "FAIL: see errors above" >> sim.log

cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
exit 0

// ==== sim/tbInterruptUnit.sv ====
`default_nettype none

`include "intUnit_params.svh"

module tbInterruptUnit import intUnitPkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD    = 8;
   localparam int RANDOM_CYCLES = 300;
   // three reset waits, one flag per source, random run and drains
   localparam int TEST_CYCLES     = 3 * (`RESET_DELAY + 12) + `INT_SOURCES * 6
                                    + RANDOM_CYCLES + 60;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 2;

   logic     MCLK;
   logic     arstN;
   logic     RSTn;
   logic     INTACK;
   srcMaskT  intFlags;
   logic     reset;
   logic     INT;
   vecIndexT intAddrLsbs;
   srcMaskT  intClr;

   // reference model of the unit
   logic       pinQ1;
   logic       pinQ2;
   logic [5:0] holdCnt;  // edges since the synchronized pin came back
   logic       expRst;
   srcMaskT    mPend;
   srcMaskT    mClr;
   logic       mAckQ;
   logic       mInt;
   vecIndexT   expIdx;

   logic [31:0] lcgState = 32'd52210;

   interruptUnit UUT (
      .MCLK        (MCLK),
      .arstN       (arstN),
      .RSTn        (RSTn),
      .INTACK      (INTACK),
      .intFlags    (intFlags),
      .reset       (reset),
      .INT         (INT),
      .intAddrLsbs (intAddrLsbs),
      .intClr      (intClr)
   );

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   // source 0 has the highest priority, -1 when the mask is empty
   function automatic int lowestSource(input srcMaskT mask);
      int idx;
      idx = -1;
      for (int i = `INT_SOURCES - 1; i >= 0; i--) begin
         if (mask[i]) idx = i;
      end
      return idx;
   endfunction

   function automatic srcMaskT lowestMask(input srcMaskT mask);
      int idx;
      idx = lowestSource(mask);
      if (idx < 0) return '0;
      return srcMaskT'(1) << idx;
   endfunction

   task automatic reportFailure(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first failing check");
   endtask

   assign expRst = (holdCnt <= 6'(`RESET_DELAY));
   assign mInt   = (mPend != '0) && !expRst;
   assign expIdx = mInt ? vecIndexT'(`VECTOR_TOP - lowestSource(mPend))
                        : vecIndexT'(`RESET_VECTOR);

   always @(posedge MCLK or negedge arstN) begin
      if (!arstN) begin
         pinQ1   <= 1'b0;
         pinQ2   <= 1'b0;
         holdCnt <= '0;
         mPend   <= '0;
         mClr    <= '0;
         mAckQ   <= 1'b0;
      end else begin
         pinQ1 <= RSTn;  // two synchronizer stages
         pinQ2 <= pinQ1;
         if (!pinQ2) begin
            holdCnt <= '0;
         end else if (holdCnt <= 6'(`RESET_DELAY)) begin
            holdCnt <= holdCnt + 6'd1;
         end
         mAckQ <= INTACK;
         if (expRst) begin
            mPend <= '0;
         end else begin
            mPend <= (mPend & ~mClr) | intFlags;  // a held flag survives its clear
         end
         mClr <= (INTACK && !mAckQ && mInt) ? lowestMask(mPend) : '0;
      end
   end

   aResetLength: assert property (@(posedge MCLK) disable iff (!arstN) reset == expRst)
      else reportFailure("reset does not follow the synchronizer and delay count");

   aPinReset: assert property (@(posedge MCLK) disable iff (!arstN) $fell(RSTn) |-> ##3 reset)
      else reportFailure("reset did not rise within three cycles of RSTn low");

   aResetOutputs: assert property (@(posedge MCLK) disable iff (!arstN)
      reset |-> (!INT && intClr == '0 && intAddrLsbs == vecIndexT'(`RESET_VECTOR)))
      else reportFailure("outputs not idle while reset is high");

   aIntLine: assert property (@(posedge MCLK) disable iff (!arstN) INT == mInt)
      else reportFailure("INT differs from the pending model");

   aVector: assert property (@(posedge MCLK) disable iff (!arstN) intAddrLsbs == expIdx)
      else reportFailure("intAddrLsbs does not name the lowest pending source");

   aClearBits: assert property (@(posedge MCLK) disable iff (!arstN) intClr == mClr)
      else reportFailure("intClr differs from the acknowledged source");

   aClearPulse: assert property (@(posedge MCLK) disable iff (!arstN)
      (intClr != '0) |=> (intClr == '0))
      else reportFailure("intClr pulse longer than one cycle");

   aHeldFlag: assert property (@(posedge MCLK) disable iff (!arstN)
      (((intClr & intFlags) != '0) && !reset) |=> INT)
      else reportFailure("flag held through its clear did not stay pending");

   initial begin
      MCLK = 1'b0;
      forever #(CLK_PERIOD / 2) MCLK = ~MCLK;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "simulation timed out");
   end

   task automatic stepCycle();
      @(posedge MCLK);
      #1;
   endtask

   task automatic waitResetDone();
      while (reset) begin
         stepCycle();
      end
   endtask

   task automatic ackPulse();
      INTACK = 1'b1;
      stepCycle();
      INTACK = 1'b0;
      stepCycle();
   endtask

   task automatic singleSource(input int src);
      intFlags = srcMaskT'(1) << src;
      stepCycle();
      intFlags = '0;
      while (!INT) begin
         stepCycle();
      end
      ackPulse();
      stepCycle();
   endtask

   task automatic runRandom(input int cycles);
      logic [31:0] r;
      int gap;
      gap = 0;
      for (int n = 0; n < cycles; n++) begin
         r = nextRand();
         intFlags = (r[31:30] == 2'b00) ? srcMaskT'(r[29:22] & r[21:14]) : '0;
         if (gap == 0) begin
            INTACK = ~INTACK;
            // high for 1 to 4 cycles, low for 1 to 4 cycles
            gap    = INTACK ? int'(r[11:10]) : int'(r[13:12]);
         end else begin
            gap--;
         end
         stepCycle();
      end
   endtask

   task automatic drainPending();
      INTACK   = 1'b0;
      intFlags = '0;
      stepCycle();
      while (INT) begin
         ackPulse();
      end
   endtask

   task automatic heldFlag();
      intFlags = srcMaskT'(8'h04);
      stepCycle();
      ackPulse();  // clear arrives while the flag is still up
      stepCycle();
      intFlags = '0;
      ackPulse();
      stepCycle();
   endtask

   task automatic pinReset();
      intFlags = srcMaskT'(8'hA5);
      stepCycle();
      intFlags = '0;
      RSTn     = 1'b0;
      repeat (6) stepCycle();
      RSTn     = 1'b1;
      intFlags = srcMaskT'(8'h3C);  // must be ignored during reset
      repeat (2) stepCycle();
      intFlags = '0;
      waitResetDone();
   endtask

   initial begin
      arstN    = 1'b0;
      RSTn     = 1'b1;
      INTACK   = 1'b0;
      intFlags = '0;
      repeat (4) @(posedge MCLK);
      #1;
      arstN = 1'b1;
      waitResetDone();
      for (int i = 0; i < `INT_SOURCES; i++) begin
         singleSource(i);
      end
      ackPulse();  // idle ack, no clear
      runRandom(RANDOM_CYCLES);
      drainPending();
      heldFlag();
      pinReset();
      repeat (4) stepCycle();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/interruptUnit.sv ====
`default_nettype none

module interruptUnit import intUnitPkg::*; (
   input  logic     MCLK,
   input  logic     arstN,
   input  logic     RSTn,         // reset pin, async to MCLK
   input  logic     INTACK,       // from CPU
   input  srcMaskT  intFlags,     // peripheral requests
   output logic     reset,        // device-wide reset
   output logic     INT,
   output vecIndexT intAddrLsbs,
   output srcMaskT  intClr        // per-peripheral clear strobes
);

   logic devReset;

   intChainIf chain ();

   resetSequencer resetSeq (
      .MCLK     (MCLK),
      .arstN    (arstN),
      .RSTn     (RSTn),
      .devReset (devReset)
   );

   pendingLatch pendLatch (
      .MCLK     (MCLK),
      .arstN    (arstN),
      .devReset (devReset),
      .intFlags (intFlags),
      .chain    (chain.latch)
   );

   priorityResolver prioRes (
      .devReset    (devReset),
      .chain       (chain.resolve),
      .INT         (INT),
      .intAddrLsbs (intAddrLsbs)
   );

   ackController ackCtrl (
      .MCLK     (MCLK),
      .arstN    (arstN),
      .devReset (devReset),
      .INTACK   (INTACK),
      .chain    (chain.ack),
      .intClr   (intClr)
   );

   assign reset = devReset;

endmodule

`default_nettype wire

// ==== source/ackController.sv ====
`default_nettype none

module ackController import intUnitPkg::*; (
   input  logic    MCLK,
   input  logic    arstN,
   input  logic    devReset,
   input  logic    INTACK,
   intChainIf.ack  chain,
   output srcMaskT intClr
);

   logic ackQ;
   logic ackRise;

   assign ackRise = INTACK & ~ackQ;  // only the rising edge counts

   always_ff @(posedge MCLK or negedge arstN) begin
      if (!arstN) begin
         ackQ <= 1'b0;
      end else begin
         ackQ <= INTACK;
      end
   end

   // grant captured at the ack edge, held for exactly one cycle
   always_ff @(posedge MCLK or negedge arstN) begin
      if (!arstN) begin
         chain.clearMask <= '0;
      end else if (ackRise && chain.anyPending && !devReset) begin
         chain.clearMask <= chain.grant;
      end else begin
         chain.clearMask <= '0;
      end
   end

   assign intClr = chain.clearMask;

   aClrSingleCycle: assert property (@(posedge MCLK) disable iff (!arstN)
      (|chain.clearMask) |=> (chain.clearMask == '0))
      else $error("clear pulse longer than one cycle");

endmodule

`default_nettype wire

// ==== source/priorityResolver.sv ====
`default_nettype none

`include "intUnit_params.svh"

module priorityResolver import intUnitPkg::*; (
   input  logic     devReset,
   intChainIf.resolve chain,
   output logic     INT,
   output vecIndexT intAddrLsbs
);

   srcMaskT  lowestBit;
   srcMaskT  grantVec;
   vecIndexT vecIdx;

   // isolate lowest set bit, source 0 has top priority
   always_comb begin
      lowestBit = chain.pending & (~chain.pending + 1'b1);
      grantVec  = devReset ? '0 : lowestBit;
   end

   always_comb begin
      vecIdx = vecIndexT'(`RESET_VECTOR);  // idle or reset
      for (int i = 0; i < `INT_SOURCES; i++) begin
         if (grantVec[i]) begin
            vecIdx = vecIndexT'(`VECTOR_TOP - i);
         end
      end
   end

   assign chain.grant      = grantVec;
   assign chain.anyPending = |grantVec;
   assign INT              = |grantVec;
   assign intAddrLsbs      = vecIdx;

   // winner is a single source that is really pending
   always_comb begin
      aGrantOneHot: assert ($onehot0(grantVec) && ((grantVec & ~chain.pending) == '0))
         else $error("grant not one-hot or not pending");
   end

endmodule

`default_nettype wire

// ==== source/pendingLatch.sv ====
`default_nettype none

module pendingLatch import intUnitPkg::*; (
   input  logic    MCLK,
   input  logic    arstN,
   input  logic    devReset,
   input  srcMaskT intFlags,
   intChainIf.latch chain
);

   srcMaskT pendingNext;

   // flags win over a clear in the same cycle
   always_comb begin
      pendingNext = (chain.pending & ~chain.clearMask) | intFlags;
   end

   always_ff @(posedge MCLK or negedge arstN) begin
      if (!arstN) begin
         chain.pending <= '0;
      end else if (devReset) begin
         chain.pending <= '0;  // device reset drops every request
      end else begin
         chain.pending <= pendingNext;
      end
   end

   // a pending bit only goes away through its own clear or device reset
   aNoLostRequest: assert property (@(posedge MCLK) disable iff (!arstN)
      !$past(devReset) |->
         ((~chain.pending & $past(chain.pending) & ~$past(chain.clearMask)) == '0))
      else $error("pending bit dropped without clear");

endmodule

`default_nettype wire

// ==== source/resetSequencer.sv ====
`default_nettype none

`include "intUnit_params.svh"

module resetSequencer import intUnitPkg::*; (
   input  logic MCLK,
   input  logic arstN,
   input  logic RSTn,
   output logic devReset
);

   logic [1:0] pinSync;  // two-flop synchronizer, [1] is safe
   resetStateT state;
   resetStateT stateNext;
   delayCountT delayCnt;

   always_ff @(posedge MCLK or negedge arstN) begin
      if (!arstN) begin
         pinSync <= '0;
      end else begin
         pinSync <= {pinSync[0], RSTn};
      end
   end

   always_comb begin
      stateNext = state;
      case (state)
         rsHold: begin
            if (pinSync[1]) stateNext = rsCount;
         end
         rsCount: begin
            if (delayCnt == delayCountT'(`RESET_DELAY - 1)) stateNext = rsRun;
         end
         default: stateNext = rsRun;
      endcase
      // pin low restarts the whole sequence
      if (!pinSync[1]) stateNext = rsHold;
   end

   always_ff @(posedge MCLK or negedge arstN) begin
      if (!arstN) begin
         state    <= rsHold;
         delayCnt <= '0;
         devReset <= 1'b1;
      end else begin
         state    <= stateNext;
         devReset <= (stateNext != rsRun);  // registered, glitch free
         if (state == rsCount) begin
            delayCnt <= delayCnt + 1'b1;
         end else begin
            delayCnt <= '0;
         end
      end
   end

   // release only at the end of a full count
   aResetHeld: assert property (@(posedge MCLK) disable iff (!arstN)
      $fell(devReset) |->
         $past((state == rsCount) && (delayCnt == delayCountT'(`RESET_DELAY - 1))))
      else $error("devReset released before the full delay count");

endmodule

`default_nettype wire

// ==== source/intChainIf.sv ====
`default_nettype none

// request, grant and clear between latch, resolver and ack logic
interface intChainIf import intUnitPkg::*; ();

   srcMaskT pending;     // sticky requests
   srcMaskT grant;       // lowest pending source, one-hot or zero
   logic    anyPending;  // same as INT
   srcMaskT clearMask;   // granted bit, one cycle after the ack edge

   modport latch (
      input  clearMask,
      output pending
   );

   modport resolve (
      input  pending,
      output grant,
      output anyPending
   );

   modport ack (
      input  grant,
      input  anyPending,
      output clearMask
   );

endinterface

`default_nettype wire

// ==== source/intUnitPkg.sv ====
`default_nettype none

`include "intUnit_params.svh"

package intUnitPkg;

   // index into the vector table, low six address bits
   typedef logic [5:0] vecIndexT;

   // one bit per interrupt source
   typedef logic [`INT_SOURCES-1:0] srcMaskT;

   typedef logic [`DELAY_BITS-1:0] delayCountT;

   // reset sequencer states
   typedef enum logic [1:0] {
      rsHold,   // pin or arstN still asserted
      rsCount,  // stretching
      rsRun
   } resetStateT;

endpackage

`default_nettype wire

// ==== source/intUnit_params.svh ====
`ifndef INTUNIT_PARAMS_SVH
`define INTUNIT_PARAMS_SVH

// maskable sources, source 0 wins
`define INT_SOURCES 8

// vector index of source 0, source i sits at VECTOR_TOP - i
`define VECTOR_TOP 60

// shown during reset and when nothing is pending
`define RESET_VECTOR 63

// cycles of device reset after the cause is gone
`define RESET_DELAY 16

// wide enough for RESET_DELAY
`define DELAY_BITS 5

`endif
